/* common/cpc_pkg.sv */
//////////////////////////////////////////////////
// CPC expansion shared definitions
// Widths, fixed ROM pages, shadowed I/O ports, enums
//////////////////////////////////////////////////

package cpc_pkg;

	//////////////////////////////////////////////////
	// Widths

	localparam int mem_addr_w = 23;  // External memory byte address
	localparam int page_w     = 9;   // 16 KB page number
	localparam int mf2_ram_aw = 13;  // 8 KB shadow RAM

	//////////////////////////////////////////////////
	// Fixed pages of the system image

	localparam logic [page_w-1:0] page_low    = 9'h000;  // Firmware
	localparam logic [page_w-1:0] page_high   = 9'h100;  // BASIC
	localparam logic [page_w-1:0] page_amsdos = 9'h107;  // Disk ROM
	localparam logic [page_w-1:0] page_mf2    = 9'h1FF;  // Multiface ROM

	// Spare page for an extension that is not hex
	localparam logic [page_w-1:0] page_malformed = 9'h1EE;

	//////////////////////////////////////////////////
	// Upper address bytes of the shadowed I/O ports

	localparam logic [7:0] port_gate_array  = 8'h7F;
	localparam logic [7:0] port_crtc_select = 8'hBC;
	localparam logic [7:0] port_crtc_data   = 8'hBD;
	localparam logic [7:0] port_ppi_control = 8'hF7;
	localparam logic [7:0] port_rom_select  = 8'hDF;

	//////////////////////////////////////////////////
	// Enums

	typedef enum logic [1:0] {
		mf2_enabled  = 2'd0,
		mf2_hidden   = 2'd1,
		mf2_disabled = 2'd2
	} mf2_mode_t;

	typedef enum logic [1:0] {
		ld_idle      = 2'd0,
		ld_write     = 2'd1,
		ld_write_dup = 2'd2  // Second copy into bank 1
	} loader_state_t;

endpackage

/* rom_loader/rom_loader.sv */
//////////////////////////////////////////////////
// ROM image loader
// Download bytes to bank/page writes, keeps the ROM map
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_loader (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          mem_ref,
	input  logic                          ioctl_download,
	input  logic [7:0]                    ioctl_index,
	input  logic [15:0]                   ioctl_file_ext,
	input  logic [24:0]                   ioctl_addr,
	input  logic [7:0]                    ioctl_dout,
	input  logic                          ioctl_wr,
	output logic                          ioctl_wait,
	output logic                          boot_wr,
	output logic [cpc_pkg::mem_addr_w-1:0] boot_addr,
	output logic [1:0]                    boot_bank,
	output logic [7:0]                    boot_dout,
	output logic [255:0]                  rom_map
);

	cpc_pkg::loader_state_t state;

	logic                      old_download;
	logic [cpc_pkg::page_w-1:0] ext_page;      // Page decoded from the extension
	logic [cpc_pkg::page_w-1:0] decoded_page;
	logic [cpc_pkg::page_w-1:0] sys_page;
	logic [4:0]                hex_hi;
	logic [4:0]                hex_lo;
	logic                      accept;
	logic                      sys_img;
	logic                      blk_ok;
	logic                      dup_mode;

	// Returns {valid, value} for one ASCII hex digit
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	always_comb begin
		hex_hi = hex_digit(ioctl_file_ext[15:8]);
		hex_lo = hex_digit(ioctl_file_ext[7:0]);
		if (ioctl_file_ext == "ZZ")
			decoded_page = '0;
		else if (hex_hi[4] && hex_lo[4])
			decoded_page = {1'b0, hex_hi[3:0], hex_lo[3:0]};
		else
			decoded_page = cpc_pkg::page_malformed;
	end

	always_comb begin
		case (ioctl_addr[15:14])  // Block number mod 4
			2'd0:    sys_page = cpc_pkg::page_low;
			2'd1:    sys_page = cpc_pkg::page_high;
			2'd2:    sys_page = cpc_pkg::page_amsdos;
			default: sys_page = cpc_pkg::page_mf2;
		endcase
	end

	assign sys_img    = (ioctl_index == 8'd0);
	assign blk_ok     = !sys_img || (ioctl_addr[24:14] < 11'd8);  // Blocks past 7 are dropped
	assign dup_mode   = (ioctl_index[7:6] == 2'b01);
	assign accept     = ioctl_download && ioctl_wr && (state == cpc_pkg::ld_idle) && blk_ok;
	assign ioctl_wait = (state != cpc_pkg::ld_idle);

	//////////////////////////////////////////////////
	// Write FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= cpc_pkg::ld_idle;
			boot_wr      <= 1'b0;
			rom_map      <= '0;
			old_download <= 1'b0;
		end else begin
			old_download <= ioctl_download;
			boot_wr      <= 1'b0;
			case (state)
				cpc_pkg::ld_idle:
					if (accept) state <= cpc_pkg::ld_write;
				cpc_pkg::ld_write, cpc_pkg::ld_write_dup: begin
					if (boot_wr) begin
						if (state == cpc_pkg::ld_write && dup_mode) begin
							state <= cpc_pkg::ld_write_dup;
						end else begin
							state <= cpc_pkg::ld_idle;
							if (boot_addr[22]) rom_map[boot_addr[21:14]] <= 1'b1;
						end
					end else if (mem_ref) begin
						boot_wr <= 1'b1;  // One write per strobe
					end
				end
				default: state <= cpc_pkg::ld_idle;
			endcase
		end
	end

	// Payload and page latch
	always_ff @(posedge clk_sys) begin
		if (!old_download && ioctl_download && !sys_img)
			ext_page <= decoded_page;
		if (accept) begin
			boot_dout        <= ioctl_dout;
			boot_addr[13:0]  <= ioctl_addr[13:0];
			if (sys_img) begin
				boot_addr[22:14] <= sys_page;
				boot_bank        <= {1'b0, ioctl_addr[16]};  // Blocks 4..7 go to bank 1
			end else begin
				boot_addr[22]    <= ext_page[8];
				boot_addr[21:14] <= ext_page[7:0] + ioctl_addr[21:14];
				boot_bank        <= {1'b0, &ioctl_index[7:6]};
			end
		end else if (state == cpc_pkg::ld_write && boot_wr && dup_mode) begin
			boot_bank <= 2'd1;
		end
	end

	// Memory writes only happen inside a download handshake
	a_wr_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		boot_wr |-> ioctl_wait);

endmodule

/* multiface/mf2_store_map.sv */
//////////////////////////////////////////////////
// Multiface shadow store map
// I/O writes to shadow RAM addresses
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mf2_store_map (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          io_wr,
	input  logic [15:0]                   cpu_addr,
	input  logic [7:0]                    cpu_dout,
	output logic [cpc_pkg::mf2_ram_aw-1:0] store_addr,
	output logic                          store_valid
);

	logic                          old_io_wr;
	logic [4:0]                    pen_index;
	logic [4:0]                    crtc_reg;
	logic [cpc_pkg::mf2_ram_aw-1:0] map_addr;
	logic                          map_hit;

	always_comb begin
		map_hit  = 1'b1;
		map_addr = '0;
		case (cpu_addr[15:8])
			cpc_pkg::port_gate_array:
				case (cpu_dout[7:6])
					2'b00: map_addr = 13'h1FCF;  // Pen select
					2'b01: map_addr = pen_index[4] ? 13'h1FDF : {9'h1F9, pen_index[3:0]};
					2'b10: map_addr = 13'h1FEF;  // Mode
					default: map_addr = 13'h1FFF;  // Banking
				endcase
			cpc_pkg::port_crtc_select: map_addr = 13'h1CFF;
			cpc_pkg::port_crtc_data:   map_addr = 13'h1DB0 + crtc_reg;
			cpc_pkg::port_ppi_control: map_addr = 13'h17FF;
			cpc_pkg::port_rom_select:  map_addr = 13'h1AAC;
			default:                   map_hit  = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_io_wr   <= 1'b0;
			store_valid <= 1'b0;
			pen_index   <= '0;
			crtc_reg    <= '0;
		end else begin
			old_io_wr   <= io_wr;
			store_valid <= io_wr && !old_io_wr && map_hit;
			if (io_wr && !old_io_wr) begin
				if (cpu_addr[15:8] == cpc_pkg::port_gate_array && cpu_dout[7:6] == 2'b00)
					pen_index <= cpu_dout[4:0];
				if (cpu_addr[15:8] == cpc_pkg::port_crtc_select)
					crtc_reg <= cpu_dout[4:0];  // Selected CRTC register
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (io_wr && !old_io_wr) store_addr <= map_addr;
	end

endmodule

/* multiface/mf2_ram.sv */
//////////////////////////////////////////////////
// Multiface 8 KB shadow RAM, registered output
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mf2_ram (
	input  logic                          clk_sys,
	input  logic [cpc_pkg::mf2_ram_aw-1:0] addr,
	input  logic [7:0]                    din,
	input  logic                          we,
	output logic [7:0]                    dout
);

	logic [7:0] mem [0:(1 << cpc_pkg::mf2_ram_aw)-1];

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= din;
			dout      <= din;  // Write-through
		end else begin
			dout <= mem[addr];
		end
	end

endmodule

/* multiface/mf2_control.sv */
//////////////////////////////////////////////////
// Multiface Two control
// NMI entry, hiding, paging windows, RAM port arbitration
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mf2_control (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  cpc_pkg::mf2_mode_t            mf2_mode,
	input  logic                          key_nmi,
	input  logic                          m1,
	input  logic                          io_wr,
	input  logic                          mem_rd,
	input  logic                          mem_wr,
	input  logic [15:0]                   cpu_addr,
	input  logic [7:0]                    cpu_dout,
	input  logic [cpc_pkg::mf2_ram_aw-1:0] store_addr,
	input  logic                          store_valid,
	input  logic [7:0]                    ram_dout,
	output logic                          nmi,
	output logic                          mf2_en,
	output logic                          mf2_rom_en,
	output logic                          mf2_ram_en,
	output logic [7:0]                    mf2_dout,
	output logic [cpc_pkg::mf2_ram_aw-1:0] ram_addr,
	output logic [7:0]                    ram_din,
	output logic                          ram_we
);

	logic       old_key_nmi;
	logic       old_m1;
	logic       old_io_wr;
	logic       hidden;
	logic [7:0] store_data;  // I/O data captured at the write edge
	logic       m1_rise;
	logic       io_rise;
	logic       entry;

	assign m1_rise = m1 && !old_m1;
	assign io_rise = io_wr && !old_io_wr;
	assign entry   = nmi && m1_rise && (cpu_addr == 16'h0066);

	assign mf2_rom_en = mf2_en && (cpu_addr[15:13] == 3'b000);  // ROM at 0000-1FFF
	assign mf2_ram_en = mf2_en && (cpu_addr[15:13] == 3'b001);  // RAM at 2000-3FFF
	assign mf2_dout   = (mf2_ram_en && mem_rd) ? ram_dout : 8'hFF;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_key_nmi <= 1'b0;
			old_m1      <= 1'b0;
			old_io_wr   <= 1'b0;
			nmi         <= 1'b0;
			mf2_en      <= 1'b0;
			hidden      <= (mf2_mode != cpc_pkg::mf2_enabled);
			ram_we      <= 1'b0;
		end else begin
			old_key_nmi <= key_nmi;
			old_m1      <= m1;
			old_io_wr   <= io_wr;

			if (key_nmi && !old_key_nmi && !mf2_en && mf2_mode != cpc_pkg::mf2_disabled)
				nmi <= 1'b1;
			if (entry) begin
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end
			if (mf2_en && m1_rise && cpu_addr == 16'h0065)
				hidden <= 1'b1;
			// FEE8 pages in, FEEA pages out
			if (io_rise && cpu_addr[15:2] == 14'b1111_1110_1110_10)
				mf2_en <= !cpu_addr[1] && !hidden;

			ram_we <= store_valid || (mem_wr && mf2_ram_en);
		end
	end

	//////////////////////////////////////////////////
	// RAM port, store first, then CPU write, else read

	always_ff @(posedge clk_sys) begin
		if (io_rise) store_data <= cpu_dout;
		if (store_valid) begin
			ram_addr <= store_addr;
			ram_din  <= store_data;
		end else begin
			ram_addr <= cpu_addr[cpc_pkg::mf2_ram_aw-1:0];
			ram_din  <= cpu_dout;
		end
	end

	a_entry_clean: assert property (@(posedge clk_sys) disable iff (reset)
		entry |=> (mf2_en && !nmi));

endmodule

/* rtl/cpc_expansion_top.sv */
//////////////////////////////////////////////////
// CPC expansion top
// ROM loader and Multiface Two cartridge
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cpc_expansion_top (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          mem_ref,
	input  logic                          ioctl_download,
	input  logic [7:0]                    ioctl_index,
	input  logic [15:0]                   ioctl_file_ext,
	input  logic [24:0]                   ioctl_addr,
	input  logic [7:0]                    ioctl_dout,
	input  logic                          ioctl_wr,
	output logic                          ioctl_wait,
	output logic                          boot_wr,
	output logic [cpc_pkg::mem_addr_w-1:0] boot_addr,
	output logic [1:0]                    boot_bank,
	output logic [7:0]                    boot_dout,
	output logic [255:0]                  rom_map,
	input  cpc_pkg::mf2_mode_t            mf2_mode,
	input  logic [15:0]                   cpu_addr,
	input  logic [7:0]                    cpu_dout,
	input  logic                          m1,
	input  logic                          io_wr,
	input  logic                          mem_rd,
	input  logic                          mem_wr,
	input  logic                          key_nmi,
	output logic                          nmi,
	output logic                          mf2_en,
	output logic                          mf2_rom_en,
	output logic                          mf2_ram_en,
	output logic [7:0]                    mf2_dout
);

	logic [cpc_pkg::mf2_ram_aw-1:0] store_addr;
	logic                          store_valid;
	logic [cpc_pkg::mf2_ram_aw-1:0] ram_addr;
	logic [7:0]                    ram_din;
	logic [7:0]                    ram_dout;
	logic                          ram_we;

	//////////////////////////////////////////////////
	// ROM loader

	rom_loader loader_i (
		.clk_sys(clk_sys), .reset(reset), .mem_ref(mem_ref),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_file_ext(ioctl_file_ext), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr), .ioctl_wait(ioctl_wait),
		.boot_wr(boot_wr), .boot_addr(boot_addr), .boot_bank(boot_bank),
		.boot_dout(boot_dout), .rom_map(rom_map)
	);

	//////////////////////////////////////////////////
	// Multiface Two

	mf2_store_map store_map_i (
		.clk_sys(clk_sys), .reset(reset), .io_wr(io_wr),
		.cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
		.store_addr(store_addr), .store_valid(store_valid)
	);

	mf2_control control_i (
		.clk_sys(clk_sys), .reset(reset), .mf2_mode(mf2_mode),
		.key_nmi(key_nmi), .m1(m1), .io_wr(io_wr), .mem_rd(mem_rd), .mem_wr(mem_wr),
		.cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
		.store_addr(store_addr), .store_valid(store_valid), .ram_dout(ram_dout),
		.nmi(nmi), .mf2_en(mf2_en), .mf2_rom_en(mf2_rom_en), .mf2_ram_en(mf2_ram_en),
		.mf2_dout(mf2_dout), .ram_addr(ram_addr), .ram_din(ram_din), .ram_we(ram_we)
	);

	mf2_ram ram_i (
		.clk_sys(clk_sys), .addr(ram_addr), .din(ram_din), .we(ram_we), .dout(ram_dout)
	);

endmodule

/* test/tb_model.svh */
//////////////////////////////////////////////////
// Testbench reference model
// Loader page and bank rules, shadow map, value check
//////////////////////////////////////////////////

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ASCII hex digit to its value, -1 when not a hex digit
function automatic int hex_nibble(input logic [7:0] c);
	if (c >= "0" && c <= "9")
		return c - "0";
	if (c >= "A" && c <= "F")
		return c - "A" + 10;
	return -1;
endfunction

// Page that a download byte lands in
function automatic logic [8:0] loader_page(input logic [7:0] index, input logic [15:0] ext,
		input logic [24:0] addr);
	int         hi;
	int         lo;
	int         blk;
	logic [8:0] base;
	blk = addr[24:14];
	if (index == 8'd0) begin
		case (blk % 4)
			0: return cpc_pkg::page_low;
			1: return cpc_pkg::page_high;
			2: return cpc_pkg::page_amsdos;
			default: return cpc_pkg::page_mf2;
		endcase
	end
	hi = hex_nibble(ext[15:8]);
	lo = hex_nibble(ext[7:0]);
	if (ext == "ZZ")
		base = 9'h000;
	else if (hi < 0 || lo < 0)
		base = cpc_pkg::page_malformed;
	else
		base = 9'(hi * 16 + lo);
	return {base[8], base[7:0] + addr[21:14]};  // Offset wraps within the low 8 bits
endfunction

// Bank of the first or the duplicated write
function automatic logic [1:0] loader_bank(input logic [7:0] index, input logic [24:0] addr,
		input bit second);
	if (index == 8'd0)
		return (addr[24:14] >= 4) ? 2'd1 : 2'd0;
	if (second)
		return 2'd1;
	return (index[7:6] == 2'b11) ? 2'd1 : 2'd0;
endfunction

function automatic bit port_is_shadowed(input logic [7:0] port);
	return port == cpc_pkg::port_gate_array || port == cpc_pkg::port_crtc_select ||
		port == cpc_pkg::port_crtc_data || port == cpc_pkg::port_ppi_control ||
		port == cpc_pkg::port_rom_select;
endfunction

// Shadow RAM address of an I/O write
function automatic logic [12:0] shadow_addr(input logic [7:0] port, input logic [7:0] data,
		input logic [4:0] pen, input logic [4:0] crtc);
	logic [12:0] a;
	a = 13'h0000;
	if (port == cpc_pkg::port_gate_array) begin
		case (data[7:6])
			2'b00: a = 13'h1FCF;
			2'b01: a = pen[4] ? 13'h1FDF : 13'h1F90 + pen[3:0];
			2'b10: a = 13'h1FEF;
			default: a = 13'h1FFF;
		endcase
	end else if (port == cpc_pkg::port_crtc_select)
		a = 13'h1CFF;
	else if (port == cpc_pkg::port_crtc_data)
		a = 13'h1DB0 + crtc;
	else if (port == cpc_pkg::port_ppi_control)
		a = 13'h17FF;
	else if (port == cpc_pkg::port_rom_select)
		a = 13'h1AAC;
	return a;
endfunction

task automatic check_value(input string name, input logic [255:0] got,
		input logic [255:0] expected);
	if (got !== expected)
		stop_on_failure($sformatf("error %s got 0x%0h expected 0x%0h", name, got, expected));
endtask

`endif

/* test/tb_cpc_expansion.sv */
//////////////////////////////////////////////////
// Testbench for the CPC expansion top
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cpc_expansion;

	logic               clk_sys;
	logic               reset;
	logic               mem_ref;
	logic               ioctl_download;
	logic [7:0]         ioctl_index;
	logic [15:0]        ioctl_file_ext;
	logic [24:0]        ioctl_addr;
	logic [7:0]         ioctl_dout;
	logic               ioctl_wr;
	logic               ioctl_wait;
	logic               boot_wr;
	logic [22:0]        boot_addr;
	logic [1:0]         boot_bank;
	logic [7:0]         boot_dout;
	logic [255:0]       rom_map;
	cpc_pkg::mf2_mode_t mf2_mode;
	logic [15:0]        cpu_addr;
	logic [7:0]         cpu_dout;
	logic               m1;
	logic               io_wr;
	logic               mem_rd;
	logic               mem_wr;
	logic               key_nmi;
	logic               nmi;
	logic               mf2_en;
	logic               mf2_rom_en;
	logic               mf2_ram_en;
	logic [7:0]         mf2_dout;

	integer       seed;
	logic [7:0]   cur_index;
	logic [15:0]  cur_ext;
	logic [255:0] exp_map;          // Expected ROM page map
	logic [22:0]  exp_addr_q[$];
	logic [1:0]   exp_bank_q[$];
	logic [7:0]   exp_dout_q[$];
	logic [4:0]   pen_model;
	logic [4:0]   crtc_model;
	logic [7:0]   shadow_model [0:8191];
	logic [12:0]  shadow_q[$];      // Shadow addresses to read back

	cpc_expansion_top dut_i (.*);

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1);
	endtask

	`include "tb_model.svh"

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = !clk_sys;
	end

	// Memory refresh strobe with random spacing
	initial begin
		seed    = 84600;
		mem_ref = 1'b0;
		forever begin
			repeat (4 + ($random(seed) & 7)) @(posedge clk_sys);
			mem_ref <= 1'b1;
			@(posedge clk_sys);
			mem_ref <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Memory write comparison

	always @(posedge clk_sys) begin
		if (!reset && boot_wr) begin
			if (exp_addr_q.size() == 0) begin
				stop_on_failure("memory write seen while none was expected");
			end else begin
				check_value("boot_addr", boot_addr, exp_addr_q.pop_front());
				check_value("boot_bank", boot_bank, exp_bank_q.pop_front());
				check_value("boot_dout", boot_dout, exp_dout_q.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////
	// Download tasks

	task automatic start_image(input logic [7:0] index, input logic [15:0] ext);
		cur_index = index;
		cur_ext   = ext;
		@(posedge clk_sys);
		ioctl_index    <= index;
		ioctl_file_ext <= ext;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sys);  // Page latched on the download edge
	endtask

	task automatic end_image;
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(posedge clk_sys);
		check_value("rom_map", rom_map, exp_map);
	endtask

	task automatic send_byte(input logic [24:0] addr);
		logic [8:0] pg;
		logic [7:0] data;
		bit         accepted;
		int         n;
		data     = addr[7:0] ^ addr[21:14] ^ 8'hA5;
		pg       = loader_page(cur_index, cur_ext, addr);
		accepted = (cur_index != 8'd0) || (addr[24:14] < 8);
		if (accepted) begin
			exp_addr_q.push_back({pg, addr[13:0]});
			exp_bank_q.push_back(loader_bank(cur_index, addr, 1'b0));
			exp_dout_q.push_back(data);
			if (cur_index[7:6] == 2'b01) begin  // Copy into bank 1 as well
				exp_addr_q.push_back({pg, addr[13:0]});
				exp_bank_q.push_back(loader_bank(cur_index, addr, 1'b1));
				exp_dout_q.push_back(data);
			end
			if (pg[8])
				exp_map[pg[7:0]] = 1'b1;
		end
		@(posedge clk_sys);
		n = 0;
		while (ioctl_wait !== 1'b0) begin
			@(posedge clk_sys);
			n++;
			if (n > 200)
				stop_on_failure("timeout waiting for the loader to be idle");
		end
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(posedge clk_sys);
		if (accepted) begin
			check_value("ioctl_wait", ioctl_wait, 1'b1);
			n = 0;
			while (ioctl_wait !== 1'b0) begin
				@(posedge clk_sys);
				n++;
				if (n > 200)
					stop_on_failure("timeout waiting for ioctl_wait to fall");
			end
			check_value("pending writes", exp_addr_q.size(), 0);
		end else begin
			repeat (4) begin
				check_value("ioctl_wait", ioctl_wait, 1'b0);
				@(posedge clk_sys);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// CPU bus tasks

	task automatic cpu_io_write(input logic [15:0] addr, input logic [7:0] data);
		logic [12:0] sa;
		if (port_is_shadowed(addr[15:8])) begin
			sa = shadow_addr(addr[15:8], data, pen_model, crtc_model);
			shadow_model[sa] = data;
			shadow_q.push_back(sa);
		end
		if (addr[15:8] == cpc_pkg::port_gate_array && data[7:6] == 2'b00)
			pen_model = data[4:0];
		if (addr[15:8] == cpc_pkg::port_crtc_select)
			crtc_model = data[4:0];
		@(posedge clk_sys);
		cpu_addr <= addr;
		cpu_dout <= data;
		io_wr    <= 1'b1;
		repeat (3) @(posedge clk_sys);
		io_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	// Data is due two cycles after mem_rd and the address
	task automatic cpu_read_check(input logic [12:0] offset, input logic [7:0] expected,
			input logic en);
		@(posedge clk_sys);
		cpu_addr <= 16'h2000 | offset;
		mem_rd   <= 1'b1;
		repeat (3) @(posedge clk_sys);
		check_value("mf2_ram_en", mf2_ram_en, en);
		check_value("mf2_dout", mf2_dout, expected);
		mem_rd <= 1'b0;
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		@(posedge clk_sys);
		cpu_addr <= addr;
		m1       <= 1'b1;
		repeat (2) @(posedge clk_sys);
		m1 <= 1'b0;
	endtask

	task automatic press_nmi_key;
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		repeat (2) @(posedge clk_sys);
		key_nmi <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Scenario

	initial begin
		int          blk;
		int          n;
		logic [12:0] sa_rd;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_file_ext = 16'd0;
		ioctl_addr     = 25'd0;
		ioctl_dout     = 8'd0;
		ioctl_wr       = 1'b0;
		mf2_mode       = cpc_pkg::mf2_enabled;
		cpu_addr       = 16'd0;
		cpu_dout       = 8'd0;
		m1             = 1'b0;
		io_wr          = 1'b0;
		mem_rd         = 1'b0;
		mem_wr         = 1'b0;
		key_nmi        = 1'b0;
		exp_map        = '0;
		pen_model      = 5'd0;
		crtc_model     = 5'd0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		// System image, then bytes past block 7
		start_image(8'h00, "SY");
		for (blk = 0; blk < 8; blk++) begin
			send_byte(blk * 25'h4000);
			send_byte(blk * 25'h4000 + 25'h1234);
			send_byte(blk * 25'h4000 + 25'h3FFF);
		end
		send_byte(25'h020000);
		send_byte(25'h02C123);
		end_image;

		// Expansion images
		start_image(8'h01, "07");
		send_byte(25'h000000);
		send_byte(25'h004000);
		send_byte(25'h008ABC);
		end_image;
		start_image(8'hC1, "A3");
		send_byte(25'h000010);
		send_byte(25'h3C0005);  // Offset wraps the page
		end_image;
		start_image(8'h02, "ZZ");
		send_byte(25'h000001);
		send_byte(25'h014000);
		end_image;
		start_image(8'h03, "Q1");  // Not hex
		send_byte(25'h000000);
		send_byte(25'h004005);
		end_image;
		start_image(8'h41, "1F");  // Bank 0 and bank 1
		send_byte(25'h000000);
		send_byte(25'h004321);
		end_image;

		// NMI ignored while the cartridge is disabled
		mf2_mode <= cpc_pkg::mf2_disabled;
		press_nmi_key;
		repeat (4) begin
			@(posedge clk_sys);
			check_value("nmi", nmi, 1'b0);
		end
		mf2_mode <= cpc_pkg::mf2_enabled;
		press_nmi_key;
		n = 0;
		while (nmi !== 1'b1) begin
			@(posedge clk_sys);
			n++;
			if (n > 20)
				stop_on_failure("timeout waiting for nmi to rise");
		end
		m1_fetch(16'h0066);
		n = 0;
		while (mf2_en !== 1'b1) begin
			@(posedge clk_sys);
			n++;
			if (n > 20)
				stop_on_failure("timeout waiting for the cartridge to page in");
		end
		check_value("nmi", nmi, 1'b0);
		check_value("mf2_rom_en", mf2_rom_en, 1'b1);

		// Shadowed register writes, read back through the RAM window
		cpu_io_write(16'h7F00, 8'h03);
		cpu_io_write(16'h7F00, 8'h4C);
		cpu_io_write(16'h7F00, 8'h10);
		cpu_io_write(16'h7F00, 8'h54);
		cpu_io_write(16'h7F00, 8'h8D);
		cpu_io_write(16'h7F00, 8'hC4);
		cpu_io_write(16'hBC00, 8'h0C);
		cpu_io_write(16'hBD00, 8'h30);
		cpu_io_write(16'hBC00, 8'h11);  // CRTC register above 15
		cpu_io_write(16'hBD00, 8'h5A);
		cpu_io_write(16'hF700, 8'h82);
		cpu_io_write(16'hDF00, 8'h07);
		while (shadow_q.size() != 0) begin
			sa_rd = shadow_q.pop_front();
			cpu_read_check(sa_rd, shadow_model[sa_rd], 1'b1);
		end

		// Paging ports, then hide
		cpu_io_write(16'hFEEA, 8'h00);
		check_value("mf2_en", mf2_en, 1'b0);
		cpu_io_write(16'hFEE8, 8'h00);
		check_value("mf2_en", mf2_en, 1'b1);
		m1_fetch(16'h0065);
		cpu_io_write(16'hFEEA, 8'h00);
		cpu_io_write(16'hFEE8, 8'h00);
		check_value("mf2_en", mf2_en, 1'b0);
		cpu_read_check(13'h1FCF, 8'hFF, 1'b0);

		$display("test passed");
		$finish;
	end

endmodule

/* files.f */
+incdir+test
common/cpc_pkg.sv
rom_loader/rom_loader.sv
multiface/mf2_store_map.sv
multiface/mf2_ram.sv
multiface/mf2_control.sv
rtl/cpc_expansion_top.sv
test/tb_cpc_expansion.sv
